/* project.f */
source/mod_params_pkg.sv
source/mod_types_pkg.sv
source/bit_if.sv
source/word_queue.sv
source/bit_serializer.sv
source/carrier_sequencer.sv
source/carrier_synth.sv
source/bpsk_transmitter.sv
verification/tb_checker.sv
verification/tb_bpsk_transmitter.sv

/* Bender.yml */
package:
  name: bpsk_transmitter

sources:
  - files:
      - source/mod_params_pkg.sv
      - source/mod_types_pkg.sv
      - source/bit_if.sv
      - source/word_queue.sv
      - source/bit_serializer.sv
      - source/carrier_sequencer.sv
      - source/carrier_synth.sv
      - source/bpsk_transmitter.sv
  - target: test
    files:
      - verification/tb_checker.sv
      - verification/tb_bpsk_transmitter.sv

/* verification/tb_bpsk_transmitter.sv */
module tb_bpsk_transmitter
    import mod_params_pkg::*;
    import mod_types_pkg::*;
();

    localparam int DATA_SIZE   = 16;
    localparam int QUEUE_DEPTH = 4;
    localparam int NUM_WORDS   = 25;   // 1 single, 4 burst, 20 random

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic [DATA_SIZE-1:0] in_data;
    logic                 in_credit;
    sample_t              sample_out;
    logic                 sample_valid;
    logic                 word_done;
    logic                 burst_mode;

    int error_count;
    int words_finished;
    int sent;
    int returned;
    int cycle_count;
    int cycle_limit;
    int errors_at_start;
    int tests_ok;
    int tests_bad;

    logic [DATA_SIZE-1:0] tbl_word [NUM_WORDS];
    int                   tbl_gap  [NUM_WORDS];   // idle cycles before the word

    bpsk_transmitter u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_credit    (in_credit),
        .sample_out   (sample_out),
        .sample_valid (sample_valid),
        .word_done    (word_done)
    );

    tb_checker #(
        .DATA_SIZE   (DATA_SIZE),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .burst_mode     (burst_mode),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .in_credit      (in_credit),
        .sample_out     (sample_out),
        .sample_valid   (sample_valid),
        .word_done      (word_done),
        .error_count    (error_count),
        .words_finished (words_finished)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic build_table();
        logic [31:0] rng;
        int          gap_sum;
        rng     = 32'd2;
        gap_sum = 0;
        tbl_word[0] = 16'hA5C3;
        tbl_word[1] = 16'hFFFF;
        tbl_word[2] = 16'h0000;
        tbl_word[3] = 16'h8001;
        tbl_word[4] = 16'h3C5A;
        for (int i = 0; i < 5; i++) tbl_gap[i] = 0;
        for (int i = 5; i < NUM_WORDS; i++) begin
            rng         = xorshift32(rng);
            tbl_word[i] = rng[DATA_SIZE-1:0];
            rng         = xorshift32(rng);
            tbl_gap[i]  = rng % 301;
        end
        for (int i = 0; i < NUM_WORDS; i++) gap_sum += tbl_gap[i];
        cycle_limit = NUM_WORDS * DATA_SIZE * WAVELENGTH + gap_sum + 200;
    endtask

    // called on a falling edge, returns on a falling edge with in_valid low
    task automatic send_word(input logic [DATA_SIZE-1:0] data, input int gap);
        repeat (gap) @(negedge clk);
        while (sent - returned >= QUEUE_DEPTH) @(negedge clk);   // out of credits
        in_valid = 1'b1;
        in_data  = data;
        sent++;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (words_finished != sent || returned != sent) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    task automatic report_test(input string name);
        if (error_count == errors_at_start) begin
            tests_ok++;
            $display("%s: ok", name);
        end else begin
            tests_bad++;
            $display("%s: FAIL with %0d errors", name, error_count - errors_at_start);
        end
        errors_at_start = error_count;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (rst_n && in_credit) returned++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        rst_n           = 1'b0;
        in_valid        = 1'b0;
        in_data         = '0;
        burst_mode      = 1'b0;
        sent            = 0;
        returned        = 0;
        cycle_count     = 0;
        errors_at_start = 0;
        tests_ok        = 0;
        tests_bad       = 0;
        build_table();

        repeat (10) @(posedge clk);   // ten reset cycles
        @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        report_test("reset state");

        send_word(tbl_word[0], tbl_gap[0]);
        wait_drain();
        report_test("single word waveform");

        burst_mode = 1'b1;
        for (int i = 1; i < 5; i++) send_word(tbl_word[i], tbl_gap[i]);
        wait_drain();
        burst_mode = 1'b0;
        report_test("back-to-back words");

        for (int i = 5; i < NUM_WORDS; i++) send_word(tbl_word[i], tbl_gap[i]);
        wait_drain();
        report_test("random traffic word boundaries");

        u_checker.check_credit_totals(sent);
        report_test("credit accounting");

        $display("results: %0d ok, %0d failing, %0d errors", tests_ok, tests_bad, error_count);
        if (tests_bad == 0 && error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* verification/tb_checker.sv */
module tb_checker
    import mod_params_pkg::*;
    import mod_types_pkg::*;
#(
    parameter int DATA_SIZE   = 16,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 burst_mode,   // queued words must follow without a gap
    input  logic                 in_valid,
    input  logic [DATA_SIZE-1:0] in_data,
    input  logic                 in_credit,
    input  sample_t              sample_out,
    input  logic                 sample_valid,
    input  logic                 word_done,
    output int                   error_count,
    output int                   words_finished
);

    logic [DATA_SIZE-1:0] expected [$];   // words accepted but not yet on the carrier
    logic [DATA_SIZE-1:0] cur_word;
    logic                 active;
    logic                 prev_valid;
    int                   bit_idx;
    int                   samp_idx;
    int                   outstanding;      // words sitting in the DUT queue
    int                   credits_seen;
    int                   reset_edges;

    initial begin
        error_count    = 0;
        words_finished = 0;
        credits_seen   = 0;
        reset_edges    = 0;
        active         = 1'b0;
        prev_valid     = 1'b0;
    end

    task automatic log_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        error_count++;
    endtask

    // folded quarter-wave sine, zero bits shifted by half a period
    function automatic sample_t predict_sample(input logic b, input int idx);
        int eff;
        int quad;
        int pos;
        int mag;
        eff  = b ? idx : (idx + HALF_PERIOD) % WAVELENGTH;
        quad = eff / QUARTER;
        pos  = eff % QUARTER;
        if (quad == 1 || quad == 3) mag = QUARTER_LUT[QUARTER - pos];
        else mag = QUARTER_LUT[pos];
        if (quad < 2) return sample_t'(SAMPLE_MID + mag);
        return sample_t'(SAMPLE_MID - mag);
    endfunction

    // every word sent must have returned its credit by now
    task automatic check_credit_totals(input int words_sent);
        if (credits_seen != words_sent)
            log_error($sformatf("%0d credit pulses for %0d words", credits_seen, words_sent));
        if (outstanding != 0)
            log_error($sformatf("%0d words still hold credits", outstanding));
    endtask

    always @(posedge clk) begin
        sample_t exp_sample;
        logic    exp_done;
        if (!rst_n) begin
            if (reset_edges > 0) begin   // outputs are unknown before the first edge
                if (in_credit !== 1'b0 || sample_valid !== 1'b0 || word_done !== 1'b0)
                    log_error("control output high during reset");
                if (sample_out !== sample_t'(SAMPLE_MID))
                    log_error($sformatf("sample_out %0d during reset", sample_out));
            end
            reset_edges++;
            expected.delete();
            active      = 1'b0;
            outstanding = 0;
            prev_valid  = 1'b0;
        end else begin
            if (in_valid) begin
                if (outstanding >= QUEUE_DEPTH) log_error("word sent without a credit");
                expected.push_back(in_data);
                outstanding++;
            end
            if (in_credit) begin
                if (outstanding == 0) log_error("credit pulse with no outstanding word");
                else outstanding--;
                credits_seen++;
            end

            if (sample_valid) begin
                if (!active) begin
                    if (expected.size() == 0) begin
                        log_error("sample with no word pending");
                    end else begin
                        cur_word = expected.pop_front();
                        active   = 1'b1;
                        bit_idx  = 0;
                        samp_idx = 0;
                    end
                end
                if (active) begin
                    exp_sample = predict_sample(cur_word[DATA_SIZE-1-bit_idx], samp_idx);
                    exp_done   = (bit_idx == DATA_SIZE - 1) && (samp_idx == WAVELENGTH - 1);
                    if (sample_out !== exp_sample)
                        log_error($sformatf("word %h bit %0d sample %0d: got %0d, expected %0d",
                                  cur_word, bit_idx, samp_idx, sample_out, exp_sample));
                    if (word_done !== exp_done)
                        log_error($sformatf("word_done %b, expected %b", word_done, exp_done));
                    if (samp_idx == WAVELENGTH - 1) begin
                        samp_idx = 0;
                        bit_idx++;
                    end else begin
                        samp_idx++;
                    end
                    if (exp_done) begin
                        active = 1'b0;
                        words_finished++;
                    end
                end
            end else begin
                if (sample_out !== sample_t'(SAMPLE_MID))
                    log_error($sformatf("idle sample_out %0d", sample_out));
                if (word_done !== 1'b0) log_error("word_done while idle");
                if (active) log_error("carrier stopped inside a word");
                if (burst_mode && prev_valid && expected.size() != 0)
                    log_error("gap between queued words");
            end
            prev_valid = sample_valid;
        end
    end

endmodule

/* source/bpsk_transmitter.sv */
module bpsk_transmitter
    import mod_types_pkg::*;
#(
    parameter int DATA_SIZE   = 16,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [DATA_SIZE-1:0] in_data,
    output logic                 in_credit,
    output sample_t              sample_out,
    output logic                 sample_valid,
    output logic                 word_done
);

    // queue to serializer
    logic                 word_valid;
    logic [DATA_SIZE-1:0] word_data;
    logic                 word_pop;

    // sequencer to synth
    logic   phase_valid;
    phase_t phase;
    logic   bit_value;
    logic   last_sample;

    bit_if u_bits ();

    word_queue #(
        .DATA_SIZE   (DATA_SIZE),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_data    (in_data),
        .in_credit  (in_credit),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_pop   (word_pop)
    );

    bit_serializer #(
        .DATA_SIZE (DATA_SIZE)
    ) u_serializer (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_pop   (word_pop),
        .bits       (u_bits.tx)
    );

    carrier_sequencer u_sequencer (
        .clk         (clk),
        .rst_n       (rst_n),
        .bits        (u_bits.rx),
        .phase_valid (phase_valid),
        .phase       (phase),
        .bit_value   (bit_value),
        .last_sample (last_sample)
    );

    carrier_synth u_synth (
        .clk          (clk),
        .rst_n        (rst_n),
        .phase_valid  (phase_valid),
        .phase        (phase),
        .bit_value    (bit_value),
        .last_sample  (last_sample),
        .sample_out   (sample_out),
        .sample_valid (sample_valid),
        .word_done    (word_done)
    );

endmodule

/* source/carrier_synth.sv */
module carrier_synth
    import mod_params_pkg::*;
    import mod_types_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    phase_valid,
    input  phase_t  phase,
    input  logic    bit_value,
    input  logic    last_sample,
    output sample_t sample_out,
    output logic    sample_valid,
    output logic    word_done
);

    phase_t     eff_phase;
    logic [1:0] quadrant;
    logic [1:0] pos;        // distance into the quadrant
    logic [2:0] lut_idx;
    sample_t    magnitude;
    sample_t    sample_next;

    // a zero bit is the same sine half a period later
    assign eff_phase = phase_t'((phase + (bit_value ? 0 : HALF_PERIOD)) % WAVELENGTH);
    assign quadrant  = 2'(eff_phase / QUARTER);
    assign pos       = 2'(eff_phase % QUARTER);

    // odd quadrants walk the table backwards
    assign lut_idx   = quadrant[0] ? 3'(QUARTER - pos) : 3'(pos);
    assign magnitude = QUARTER_LUT[lut_idx];

    // second half of the period swings below midpoint
    assign sample_next = quadrant[1] ? sample_t'(SAMPLE_MID) - magnitude
                                     : sample_t'(SAMPLE_MID) + magnitude;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_out   <= sample_t'(SAMPLE_MID);
            sample_valid <= 1'b0;
            word_done    <= 1'b0;
        end else begin
            sample_out   <= phase_valid ? sample_next : sample_t'(SAMPLE_MID);
            sample_valid <= phase_valid;
            word_done    <= last_sample;   // lines up with the final sample of a word
        end
    end

endmodule

/* source/carrier_sequencer.sv */
module carrier_sequencer
    import mod_params_pkg::*;
    import mod_types_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    bit_if.rx      bits,
    output logic   phase_valid,
    output phase_t phase,
    output logic   bit_value,
    output logic   last_sample
);

    localparam int BUF_W = (BIT_CREDITS > 1) ? $clog2(BIT_CREDITS) : 1;

    logic             buf_value [BIT_CREDITS];
    logic             buf_last  [BIT_CREDITS];
    logic [BUF_W-1:0] wr_idx;
    logic [BUF_W-1:0] rd_idx;
    credit_t          buf_count;

    logic   playing;     // a bit is on the carrier
    logic   cur_value;
    logic   cur_last;
    phase_t phase_q;
    logic   at_end;
    logic   start;

    assign at_end = phase_q == phase_t'(WAVELENGTH - 1);
    // next buffered bit begins right after phase 15, or at once when idle
    assign start  = (buf_count != '0) && (!playing || at_end);

    assign phase_valid = playing;
    assign phase       = phase_q;
    assign bit_value   = cur_value;
    assign last_sample = playing && cur_last && at_end;

    always_ff @(posedge clk) begin
        if (bits.valid) begin
            buf_value[wr_idx] <= bits.value;
            buf_last[wr_idx]  <= bits.last;
        end
        if (start) begin
            cur_value <= buf_value[rd_idx];
            cur_last  <= buf_last[rd_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_idx      <= '0;
            rd_idx      <= '0;
            buf_count   <= '0;
            playing     <= 1'b0;
            phase_q     <= '0;
            bits.credit <= 1'b0;
        end else begin
            if (bits.valid) wr_idx <= (wr_idx == BUF_W'(BIT_CREDITS - 1)) ? '0 : wr_idx + 1'b1;
            if (start) rd_idx <= (rd_idx == BUF_W'(BIT_CREDITS - 1)) ? '0 : rd_idx + 1'b1;

            case ({bits.valid, start})
                2'b10:   buf_count <= buf_count + 1'b1;
                2'b01:   buf_count <= buf_count - 1'b1;
                default: buf_count <= buf_count;
            endcase

            if (start) playing <= 1'b1;
            else if (at_end) playing <= 1'b0;

            if (start || at_end) phase_q <= '0;
            else if (playing) phase_q <= phase_q + 1'b1;

            bits.credit <= start;   // slot freed as the bit leaves the buffer
        end
    end

    // serializer credits bound what can arrive, so the buffer never overflows
    a_buffer_overflow: assert property (
        @(posedge clk) disable iff (!rst_n)
        bits.valid |-> buf_count < credit_t'(BIT_CREDITS)
    ) else $error("bit arrived with the buffer full");

endmodule

/* source/bit_serializer.sv */
module bit_serializer
    import mod_params_pkg::*;
    import mod_types_pkg::*;
#(
    parameter int DATA_SIZE = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 word_valid,
    input  logic [DATA_SIZE-1:0] word_data,
    output logic                 word_pop,
    bit_if.tx                    bits
);

    localparam int CNT_W = $clog2(DATA_SIZE + 1);

    logic [DATA_SIZE-1:0] shift_q;     // msb is the next bit out
    logic [CNT_W-1:0]     remaining;   // bits of the current word not yet sent
    credit_t              credits;
    logic                 send;
    logic                 load;

    assign send = (remaining != '0) && (credits != '0);
    // take the next word when idle or while the final bit goes out
    assign load = word_valid && ((remaining == '0) || (send && remaining == CNT_W'(1)));

    assign word_pop   = load;
    assign bits.valid = send;
    assign bits.value = shift_q[DATA_SIZE-1];
    assign bits.last  = remaining == CNT_W'(1);

    always_ff @(posedge clk) begin
        if (load) shift_q <= word_data;
        else if (send) shift_q <= shift_q << 1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining <= '0;
            credits   <= credit_t'(BIT_CREDITS);
        end else begin
            if (load) remaining <= CNT_W'(DATA_SIZE);
            else if (send) remaining <= remaining - 1'b1;

            case ({send, bits.credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // sequencer must never hand back more slots than it granted
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        credits <= credit_t'(BIT_CREDITS)
    ) else $error("bit credit count above grant");

endmodule

/* source/word_queue.sv */
module word_queue
    import mod_types_pkg::*;
#(
    parameter int DATA_SIZE   = 16,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [DATA_SIZE-1:0] in_data,
    output logic                 in_credit,
    output logic                 word_valid,
    output logic [DATA_SIZE-1:0] word_data,
    input  logic                 word_pop
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    logic [DATA_SIZE-1:0] mem [QUEUE_DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    credit_t              count;
    logic                 pop;

    assign word_valid = count != '0;
    assign word_data  = mem[rd_ptr];
    assign pop        = word_pop && word_valid;
    assign in_credit  = pop;   // a freed slot goes straight back upstream

    always_ff @(posedge clk) begin
        if (in_valid) mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the sender spends credits, so a write never lands on a full queue
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(in_valid && count == credit_t'(QUEUE_DEPTH))
    ) else $error("word written into a full queue");

endmodule

/* source/bit_if.sv */
// serial bit link with credit return

interface bit_if;

    logic valid;    // one bit offered this cycle
    logic value;    // the bit itself
    logic last;     // lsb of its word
    logic credit;   // one bit slot freed in the sequencer

    modport tx (
        output valid,
        output value,
        output last,
        input  credit
    );

    modport rx (
        input  valid,
        input  value,
        input  last,
        output credit
    );

endinterface

/* source/mod_types_pkg.sv */
package mod_types_pkg;

    import mod_params_pkg::*;

    // one unsigned DAC sample
    typedef logic [SAMPLE_WIDTH-1:0] sample_t;

    // sample index within one carrier period
    typedef logic [$clog2(WAVELENGTH)-1:0] phase_t;

    // credit or occupancy count, sized for the queue depth
    typedef logic [3:0] credit_t;

endpackage

/* source/mod_params_pkg.sv */
package mod_params_pkg;

    // carrier timing
    localparam int WAVELENGTH  = 16;   // samples per bit
    localparam int HALF_PERIOD = 8;    // phase offset applied to a zero bit
    localparam int QUARTER     = 4;    // samples per quadrant

    // DAC sample format, offset binary
    localparam int SAMPLE_WIDTH = 12;
    localparam int SAMPLE_MID   = 2048;   // zero level of the carrier, also idle

    // quarter-wave magnitudes indexed by distance into the quadrant
    // entry QUARTER is the crest
    localparam logic [SAMPLE_WIDTH-1:0] QUARTER_LUT [0:QUARTER] = '{
        12'd0,
        12'd784,
        12'd1448,
        12'd1892,
        12'd2047
    };

    // bit slots the sequencer can hold ahead of the bit being played
    localparam int BIT_CREDITS = 2;

endpackage
